//--- hw/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic            i_clk,
    input  logic            i_rst,                // Sync, active high
    input  mem_pkg::ex_mem_t i_ex,                // Payload from EX
    input  logic            i_advance,            // Memory ready and valid
    output mem_pkg::ex_mem_t o_stage              // Registered EX/MEM payload
);

    import mem_pkg::*;

    // ============================================================
    // EX/MEM boundary register
    // ============================================================
    ex_mem_t r_q;                                 // Current MEM slot

    // Only controls and valid see reset
    // Address, data, rd and funct3 are don't-care while valid is low
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_q.mem_read   <= 1'b0;               // No load
            r_q.mem_write  <= 1'b0;               // No store
            r_q.mem_to_reg <= 1'b0;
            r_q.reg_write  <= 1'b0;               // No rd write
            r_q.valid      <= 1'b0;               // Bubble
        end else if (i_advance) begin
            r_q <= i_ex;                          // Take next instruction
        end
        // Else hold the whole slot, stall comes from the top level
    end

    assign o_stage = r_q;                         // Feeds all MEM logic

endmodule

//--- hw/load_unit.sv
`timescale 1ns/1ps

module load_unit (
    input  logic [mem_pkg::XLEN-1:0] i_rdata,     // Merged read word
    input  logic [1:0]               i_offset,    // Byte within word
    input  logic [2:0]               i_funct3,    // Load size and sign
    output logic [mem_pkg::XLEN-1:0] o_load_data  // Value for rd
);

    import mem_pkg::*;

    logic [7:0]  lane_b;                          // Addressed byte
    logic [15:0] lane_h;                          // Addressed halfword

    // ============================================================
    // Lane selection
    // ============================================================
    always_comb begin
        case (i_offset)
            2'd0:    lane_b = i_rdata[7:0];
            2'd1:    lane_b = i_rdata[15:8];
            2'd2:    lane_b = i_rdata[23:16];
            default: lane_b = i_rdata[31:24];
        endcase
    end

    // High offset bit picks the half, bit 0 is the misaligned case
    assign lane_h = i_offset[1] ? i_rdata[XLEN-1:16] : i_rdata[15:0];

    // ============================================================
    // Extension
    // ============================================================
    always_comb begin
        case (i_funct3)
            F3_LB: begin
                o_load_data = {{(XLEN-8){lane_b[7]}}, lane_b};      // Sign fill
            end
            F3_LH: begin
                o_load_data = {{(XLEN-16){lane_h[15]}}, lane_h};    // Sign fill
            end
            F3_LW: begin
                o_load_data = i_rdata;                              // Whole word
            end
            F3_LBU: begin
                o_load_data = {{(XLEN-8){1'b0}}, lane_b};           // Zero fill
            end
            F3_LHU: begin
                o_load_data = {{(XLEN-16){1'b0}}, lane_h};          // Zero fill
            end
            default: begin
                o_load_data = i_rdata;                              // Unknown code, raw word
            end
        endcase
    end

endmodule

//--- hw/mem_access_gen.sv
`timescale 1ns/1ps

module mem_access_gen (
    input  mem_pkg::ex_mem_t   i_stage,           // Registered EX/MEM slot
    output mem_pkg::dmem_req_t o_req,             // Request to data memory
    output logic [1:0]         o_offset,          // Byte within word
    output logic               o_misaligned       // Access breaks natural alignment
);

    import mem_pkg::*;

    logic [1:0]        size;                      // funct3 size field
    logic [MASK_W-1:0] lanes;                     // Unshifted byte enables
    logic              is_mem;                    // Load or store present
    logic              word_bad;
    logic              half_bad;

    assign size     = i_stage.funct3[1:0];
    assign o_offset = i_stage.alu_result[1:0];    // Low address bits
    assign is_mem   = i_stage.mem_read | i_stage.mem_write;

    // ============================================================
    // Address and strobes
    // ============================================================
    assign o_req.addr = {i_stage.alu_result[XLEN-1:2], 2'b00};  // Drop byte offset
    assign o_req.ren  = i_stage.mem_read;
    assign o_req.wen  = i_stage.mem_write;

    // ============================================================
    // Byte mask and store lanes
    // ============================================================
    always_comb begin
        case (size)
            F3_SB[1:0]: lanes = 4'b0001;          // One lane
            F3_SH[1:0]: lanes = 4'b0011;          // Two lanes
            F3_SW[1:0]: lanes = 4'b1111;          // Full word
            default:    lanes = 4'b1111;          // Unused code, treat as word
        endcase
    end

    assign o_req.mask = lanes << o_offset;        // Move to addressed lane

    // Byte data goes to its lane, 8 bits per offset step
    assign o_req.wdata = i_stage.rs2_data << {o_offset, 3'b000};

    // ============================================================
    // Misalignment flag
    // ============================================================
    // Loads and stores share the size encoding
    assign word_bad = (size == F3_SW[1:0]) && (o_offset != 2'b00);   // Word off boundary
    assign half_bad = (size == F3_SH[1:0]) && o_offset[0];          // Half at odd byte

    assign o_misaligned = is_mem && (word_bad || half_bad);

endmodule

//--- hw/mem_pkg.sv
package mem_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int XLEN       = 32;                 // Data and address width
    localparam int REG_ADDR_W = 5;                  // Register number width
    localparam int MASK_W     = XLEN / 8;           // Byte lanes per word

    // ============================================================
    // funct3 size codes
    // ============================================================
    localparam logic [2:0] F3_LB  = 3'b000;         // Load byte, signed
    localparam logic [2:0] F3_LH  = 3'b001;         // Load half, signed
    localparam logic [2:0] F3_LW  = 3'b010;         // Load word
    localparam logic [2:0] F3_LBU = 3'b100;         // Load byte, unsigned
    localparam logic [2:0] F3_LHU = 3'b101;         // Load half, unsigned

    localparam logic [2:0] F3_SB  = 3'b000;         // Store byte
    localparam logic [2:0] F3_SH  = 3'b001;         // Store half
    localparam logic [2:0] F3_SW  = 3'b010;         // Store word

    // ============================================================
    // Stage structs
    // ============================================================
    // Payload handed over from EX, 77 bits
    typedef struct packed {
        logic [XLEN-1:0]       alu_result;          // Effective address or ALU value
        logic [XLEN-1:0]       rs2_data;            // Store source
        logic [REG_ADDR_W-1:0] rd;                  // Destination register
        logic [2:0]            funct3;              // Access size and sign
        logic                  mem_read;            // Load
        logic                  mem_write;           // Store
        logic                  mem_to_reg;          // WB takes load data
        logic                  reg_write;           // Writes rd
        logic                  valid;               // Slot holds an instruction
    } ex_mem_t;

    // Data memory request, 70 bits
    typedef struct packed {
        logic [XLEN-1:0]   addr;                    // Word aligned
        logic              ren;                     // Read strobe
        logic              wen;                     // Write strobe
        logic [XLEN-1:0]   wdata;                   // Already in its byte lanes
        logic [MASK_W-1:0] mask;                    // Byte enables
    } dmem_req_t;

    // Registered values for the hazard unit, 40 bits
    typedef struct packed {
        logic [XLEN-1:0]       alu_result;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic                  mem_to_reg;          // Load in MEM, result not ready
        logic                  valid;
    } fwd_t;

    // Values passed on to WB, 72 bits
    typedef struct packed {
        logic [XLEN-1:0]       load_data;           // Extended load result
        logic [XLEN-1:0]       alu_result;
        logic [REG_ADDR_W-1:0] rd;
        logic                  mem_to_reg;
        logic                  reg_write;
        logic                  valid;
    } wb_t;

endpackage

//--- hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                     i_clk,
    input  logic                     i_rst,          // Sync, active high

    // EX side
    input  mem_pkg::ex_mem_t         i_ex,           // Next instruction from EX

    // Data memory
    input  logic [mem_pkg::XLEN-1:0] i_dmem_rdata,   // Raw read word
    input  logic                     i_dmem_ready,
    input  logic                     i_dmem_valid,
    output mem_pkg::dmem_req_t       o_dmem,         // Aligned request

    // Hazard unit and WB
    output mem_pkg::fwd_t            o_fwd,          // Registered slot values
    output mem_pkg::wb_t             o_wb,           // Values for MEM/WB
    output logic                     o_misaligned    // Alignment trap
);

    import mem_pkg::*;

    // ============================================================
    // Internal signals
    // ============================================================
    logic            advance;                        // Stage moves this edge
    ex_mem_t         r_stage;                        // Current MEM slot
    logic [1:0]      offset;                         // Byte offset of access
    logic [XLEN-1:0] rdata_fwd;                      // Read data after forwarding
    logic [XLEN-1:0] load_data;                      // Extended load value

    // One-level stall, both memory levels must be high
    assign advance = i_dmem_ready & i_dmem_valid;

    // ============================================================
    // Datapath
    // ============================================================
    ex_mem_reg u_ex_mem_reg (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_ex      (i_ex),
        .i_advance (advance),
        .o_stage   (r_stage)
    );

    mem_access_gen u_access (
        .i_stage      (r_stage),
        .o_req        (o_dmem),
        .o_offset     (offset),
        .o_misaligned (o_misaligned)
    );

    // History runs on every edge, stalled or not
    store_forward u_store_fwd (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_req   (o_dmem),
        .i_rdata (i_dmem_rdata),
        .o_rdata (rdata_fwd)
    );

    load_unit u_load (
        .i_rdata     (rdata_fwd),
        .i_offset    (offset),
        .i_funct3    (r_stage.funct3),
        .o_load_data (load_data)
    );

    // ============================================================
    // Output packing
    // ============================================================
    assign o_fwd.alu_result = r_stage.alu_result;   // EX/MEM bypass value
    assign o_fwd.rd         = r_stage.rd;
    assign o_fwd.reg_write  = r_stage.reg_write;
    assign o_fwd.mem_to_reg = r_stage.mem_to_reg;   // Load-use check
    assign o_fwd.valid      = r_stage.valid;

    assign o_wb.load_data   = load_data;
    assign o_wb.alu_result  = r_stage.alu_result;
    assign o_wb.rd          = r_stage.rd;
    assign o_wb.mem_to_reg  = r_stage.mem_to_reg;
    assign o_wb.reg_write   = r_stage.reg_write;
    assign o_wb.valid       = r_stage.valid;

endmodule

//--- hw/store_forward.sv
`timescale 1ns/1ps

module store_forward (
    input  logic                       i_clk,
    input  logic                       i_rst,     // Sync, active high
    input  mem_pkg::dmem_req_t         i_req,     // This cycle's request
    input  logic [mem_pkg::XLEN-1:0]   i_rdata,   // Raw memory read data
    output logic [mem_pkg::XLEN-1:0]   o_rdata    // Read data with store bytes merged
);

    import mem_pkg::*;

    // ============================================================
    // Previous-cycle write history
    // ============================================================
    logic [XLEN-1:0]   r_prev_addr;               // Aligned address
    logic [XLEN-1:0]   r_prev_wdata;              // Lane-shifted data
    logic [MASK_W-1:0] r_prev_mask;               // Written lanes
    logic              r_prev_wen;                // Last cycle was a store

    // Samples every edge, memory commits one cycle late
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_prev_addr  <= '0;
            r_prev_wdata <= '0;
            r_prev_mask  <= '0;
            r_prev_wen   <= 1'b0;
        end else begin
            r_prev_addr  <= i_req.addr;
            r_prev_wdata <= i_req.wdata;
            r_prev_mask  <= i_req.mask;
            r_prev_wen   <= i_req.wen;
        end
    end

    // ============================================================
    // Hit detection and byte merge
    // ============================================================
    logic            hit;                         // Load follows store to same word
    logic [XLEN-1:0] merged;

    assign hit = r_prev_wen && i_req.ren && (r_prev_addr == i_req.addr);

    always_comb begin
        merged = i_rdata;                         // Start from stale word
        for (int i = 0; i < MASK_W; i++) begin
            if (r_prev_mask[i]) begin
                merged[8*i +: 8] = r_prev_wdata[8*i +: 8];   // Newer store byte
            end
        end
    end

    assign o_rdata = hit ? merged : i_rdata;

endmodule

//--- tb.f
hw/mem_pkg.sv
hw/ex_mem_reg.sv
hw/mem_access_gen.sv
hw/store_forward.sv
hw/load_unit.sv
hw/mem_stage.sv
test/mem_stage_assertions.sv
test/tb_mem_stage.sv

//--- test/mem_stage_assertions.sv
`timescale 1ns/1ps

module mem_stage_assertions (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_dmem_ready,
    input  logic                 i_dmem_valid,
    input  mem_pkg::dmem_req_t   o_dmem,
    input  mem_pkg::fwd_t        o_fwd
);

    import mem_pkg::*;

    logic advance;                                // Stage moves this edge
    int   fail_count = 0;                         // Failed assertion count

    assign advance = i_dmem_ready & i_dmem_valid;

    // ============================================================
    // Request sanity
    // ============================================================
    a_no_rw_overlap: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_dmem.ren && o_dmem.wen))
        else begin
            $error("ren and wen high together");
            fail_count++;
        end

    // Word aligned copy of the slot address
    a_addr_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        o_dmem.addr == {o_fwd.alu_result[XLEN-1:2], 2'b00})
        else begin
            $error("request address not the word aligned slot address");
            fail_count++;
        end

    a_mask_on_write: assert property (@(posedge i_clk) disable iff (i_rst)
        o_dmem.wen |-> (o_dmem.mask != '0))
        else begin
            $error("write with empty byte mask");
            fail_count++;
        end

    // Hazard view must freeze under back-pressure
    a_fwd_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        !advance |=> $stable(o_fwd))
        else begin
            $error("o_fwd changed while stalled");
            fail_count++;
        end

endmodule

//--- test/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;

    import mem_pkg::*;

    logic               i_clk;
    logic               i_rst;
    ex_mem_t            i_ex;
    logic [XLEN-1:0]    i_dmem_rdata;
    logic               i_dmem_ready;
    logic               i_dmem_valid;
    dmem_req_t          o_dmem;
    fwd_t               o_fwd;
    wb_t                o_wb;
    logic               o_misaligned;

    mem_stage u_dut (.*);

    bind mem_stage mem_stage_assertions u_sva (.*);

    // ============================================================
    // Clock
    // ============================================================
    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;                // 10 ns period
    end

    // ============================================================
    // Memory and reference model
    // ============================================================
    logic [XLEN-1:0] mem [0:15];                  // What the DUT reads, commits late
    logic [XLEN-1:0] model_mem [0:15];            // True contents, commits at once
    ex_mem_t         m_stage = '0;                // Model copy of the stage register
    logic            m_adv_last = 1'b0;           // Last edge advanced
    logic            pend_en = 1'b0;              // Delayed write pending
    logic [3:0]      pend_idx;
    logic [XLEN-1:0] pend_data;
    logic [3:0]      pend_mask;

    logic [XLEN-1:0] exp_addr, exp_wdata, exp_load, word;
    logic [3:0]      exp_mask, lanes;
    logic            exp_mis;
    logic [1:0]      off;
    logic [7:0]      sel_b;
    logic [15:0]     sel_h;

    assign i_dmem_rdata = mem[o_dmem.addr[5:2]];  // Stale until pending write lands

    function automatic logic [XLEN-1:0] merge_bytes(logic [XLEN-1:0] old_w,
                                                    logic [XLEN-1:0] new_w, logic [3:0] m);
        logic [XLEN-1:0] r;
        r = old_w;
        for (int i = 0; i < 4; i++) begin
            if (m[i]) r[8*i +: 8] = new_w[8*i +: 8];
        end
        return r;
    endfunction

    always_comb begin
        off       = m_stage.alu_result[1:0];
        exp_addr  = {m_stage.alu_result[31:2], 2'b00};
        lanes     = (m_stage.funct3[1:0] == 2'd0) ? 4'h1 :
                    (m_stage.funct3[1:0] == 2'd1) ? 4'h3 : 4'hf;
        exp_mask  = 4'(lanes << off);
        exp_wdata = m_stage.rs2_data << (8 * off);
        exp_mis   = (m_stage.mem_read || m_stage.mem_write) &&
                    ((m_stage.funct3[1:0] == 2'd2 && off != 2'd0) ||
                     (m_stage.funct3[1:0] == 2'd1 && off[0]));
        word      = model_mem[m_stage.alu_result[5:2]];
        sel_b     = word >> (8 * off);
        sel_h     = off[1] ? word[31:16] : word[15:0];
        case (m_stage.funct3)
            3'b000:  exp_load = {{24{sel_b[7]}}, sel_b};    // LB
            3'b001:  exp_load = {{16{sel_h[15]}}, sel_h};   // LH
            3'b100:  exp_load = {24'd0, sel_b};             // LBU
            3'b101:  exp_load = {16'd0, sel_h};             // LHU
            default: exp_load = word;
        endcase
    end

    always @(posedge i_clk) begin
        if (pend_en) mem[pend_idx] = merge_bytes(mem[pend_idx], pend_data, pend_mask);
        pend_en   = !i_rst && m_stage.mem_write;  // Lands one edge later
        pend_idx  = exp_addr[5:2];
        pend_data = exp_wdata;
        pend_mask = exp_mask;
        if (pend_en) model_mem[pend_idx] = merge_bytes(model_mem[pend_idx], exp_wdata, exp_mask);
        m_adv_last <= i_dmem_ready && i_dmem_valid;
        if (i_rst) begin
            m_stage.mem_read  <= 1'b0;
            m_stage.mem_write <= 1'b0;
            m_stage.mem_to_reg <= 1'b0;
            m_stage.reg_write <= 1'b0;
            m_stage.valid     <= 1'b0;
        end else if (i_dmem_ready && i_dmem_valid) begin
            m_stage <= i_ex;
        end
    end

    // ============================================================
    // Checks
    // ============================================================
    string     cur_test;
    int        test_errs, total_errs, tests_run, tests_failed;
    bit        have_prev;
    fwd_t      prev_fwd;
    dmem_req_t prev_dmem;

    task automatic check_val(string what, logic [79:0] exp, logic [79:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_outputs();
        check_val("addr", exp_addr, o_dmem.addr);
        check_val("ren", m_stage.mem_read, o_dmem.ren);
        check_val("wen", m_stage.mem_write, o_dmem.wen);
        check_val("misaligned", exp_mis, o_misaligned);
        check_val("fwd", {m_stage.alu_result, m_stage.rd, m_stage.reg_write,
                          m_stage.mem_to_reg, m_stage.valid}, o_fwd);
        check_val("wb.rd", m_stage.rd, o_wb.rd);
        check_val("wb.alu_result", m_stage.alu_result, o_wb.alu_result);
        check_val("wb.mem_to_reg", m_stage.mem_to_reg, o_wb.mem_to_reg);
        check_val("wb.reg_write", m_stage.reg_write, o_wb.reg_write);
        check_val("wb.valid", m_stage.valid, o_wb.valid);
        check_val("mask", exp_mask, o_dmem.mask);
        if (m_stage.mem_write) check_val("wdata", exp_wdata, o_dmem.wdata);
        if (m_stage.mem_read && m_stage.valid && !exp_mis) begin
            check_val("load_data", exp_load, o_wb.load_data);
        end
        if (have_prev && !m_adv_last) begin
            check_val("held fwd", prev_fwd, o_fwd);
            check_val("held dmem", prev_dmem, o_dmem);
        end
        prev_fwd  = o_fwd;
        prev_dmem = o_dmem;
        have_prev = 1'b1;
    endtask

    // ============================================================
    // Stimulus helpers
    // ============================================================
    // kind 0 ALU, 1 load, 2 store
    function automatic ex_mem_t make_instr(int kind, logic [2:0] f3, logic [3:0] w,
                                           logic [1:0] o);
        ex_mem_t e;
        e.alu_result = (kind == 0) ? $urandom : {26'd0, w, o};
        e.rs2_data   = $urandom;
        e.rd         = $urandom;
        e.funct3     = f3;
        e.mem_read   = (kind == 1);
        e.mem_write  = (kind == 2);
        e.mem_to_reg = (kind == 1);
        e.reg_write  = (kind != 2);
        e.valid      = 1'b1;
        return e;
    endfunction

    // Entered on a falling edge, returns on the falling edge after capture
    task automatic issue(ex_mem_t ins, bit stall);
        int  n;
        bit  adv;
        n   = 0;
        adv = 1'b0;
        i_ex = ins;
        while (!adv) begin
            i_dmem_ready = (stall && n < 6) ? ($urandom % 4 != 0) : 1'b1;
            i_dmem_valid = (stall && n < 6) ? ($urandom % 4 != 0) : 1'b1;
            #4;
            check_outputs();
            adv = i_dmem_ready && i_dmem_valid;
            @(negedge i_clk);
            n++;
            if (n > 20) begin
                $display("Timeout: stage did not advance in %s", cur_test);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    endtask

    task automatic start_test(string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        issue('0, 1'b0);                          // Bubble drains the last check
        tests_run++;
        if (test_errs != 0) tests_failed++;
        total_errs += test_errs;
        $display("%-10s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "failed",
                 test_errs);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int  k;
        bit  b;
        logic [1:0] o;
        logic [3:0] w;
        void'($urandom(90));
        for (int i = 0; i < 16; i++) begin
            mem[i]       = {4{4'(i), 4'(~i)}} ^ 32'h5a3c_96e1;
            model_mem[i] = mem[i];
        end
        i_rst = 1'b1;
        i_ex = make_instr(2, F3_SW, 4'd1, 2'd0);  // Junk that reset must mask
        i_dmem_ready = 1'b1;
        i_dmem_valid = 1'b1;
        @(posedge i_clk);                         // First edge applies reset

        start_test("reset");
        for (int c = 0; c < 10; c++) begin
            @(negedge i_clk);
            check_val("ren", 1'b0, o_dmem.ren);
            check_val("wen", 1'b0, o_dmem.wen);
            check_val("wb.valid", 1'b0, o_wb.valid);
            check_val("fwd.reg_write", 1'b0, o_fwd.reg_write);
            check_val("misaligned", 1'b0, o_misaligned);
        end
        i_rst = 1'b0;
        i_ex  = '0;
        @(negedge i_clk);                         // First edge out of reset
        check_val("ren", 1'b0, o_dmem.ren);
        check_val("wen", 1'b0, o_dmem.wen);
        check_val("wb.valid", 1'b0, o_wb.valid);
        check_val("misaligned", 1'b0, o_misaligned);
        end_test();

        start_test("stores");
        for (int i = 0; i < 40; i++) begin
            k = $urandom % 3;
            o = (k == 0) ? 2'($urandom) : (k == 1) ? {1'($urandom), 1'b0} : 2'd0;
            issue(make_instr(2, 3'(k), 4'($urandom), o), 1'b0);
        end
        end_test();

        start_test("loads");
        for (int i = 0; i < 40; i++) begin
            k = $urandom % 5;
            case (k)
                0: issue(make_instr(1, F3_LB, 4'($urandom), 2'($urandom)), 1'b0);
                1: issue(make_instr(1, F3_LBU, 4'($urandom), 2'($urandom)), 1'b0);
                2: issue(make_instr(1, F3_LH, 4'($urandom), {1'($urandom), 1'b0}), 1'b0);
                3: issue(make_instr(1, F3_LHU, 4'($urandom), {1'($urandom), 1'b0}), 1'b0);
                default: issue(make_instr(1, F3_LW, 4'($urandom), 2'd0), 1'b0);
            endcase
        end
        end_test();

        start_test("forward");
        for (int i = 0; i < 20; i++) begin
            w = $urandom;
            issue(make_instr(2, F3_SB, w, 2'($urandom)), 1'b0);
            issue(make_instr(1, F3_LW, w, 2'd0), 1'b0);           // Same word, merged
            issue(make_instr(2, F3_SH, w, 2'd2), 1'b0);
            issue(make_instr(1, F3_LW, w + 4'd1, 2'd0), 1'b0);    // Other word, plain
            issue(make_instr(1, F3_LHU, w, 2'd2), 1'b0);
        end
        end_test();

        start_test("misalign");
        for (int i = 0; i < 30; i++) begin
            k = $urandom % 3;
            b = $urandom;
            if (k == 0) begin
                issue(make_instr(b ? 1 : 2, F3_LW, 4'($urandom), 2'($urandom % 3 + 1)), 1'b0);
            end else if (k == 1) begin
                issue(make_instr(b ? 1 : 2, F3_LH, 4'($urandom), {1'($urandom), 1'b1}), 1'b0);
            end else begin
                issue(make_instr(0, 3'($urandom), 4'd0, 2'd0), 1'b0);  // Never flags
            end
        end
        end_test();

        start_test("stall");
        for (int i = 0; i < 40; i++) begin
            k = $urandom % 3;
            issue(make_instr(k, (k == 0) ? 3'($urandom) : F3_LW, 4'($urandom), 2'd0), 1'b1);
        end
        end_test();

        total_errs += u_dut.u_sva.fail_count;     // Bound concurrent assertions
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
